// ==== src/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Associativity
`define CACHE_WAYS_W 1
`define CACHE_WAYS (1 << `CACHE_WAYS_W)

// Lanes kept few so tests can force conflicts
`define CACHE_LANES_W 2
`define CACHE_LANES (1 << `CACHE_LANES_W)

// Four 32-bit words per line, 16 bytes
`define CACHE_OFFSET_W 2
`define CACHE_WORDS (1 << `CACHE_OFFSET_W)

// Byte address and what remains for the tag
`define CACHE_ADDR_W 32
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_LANES_W - `CACHE_OFFSET_W - 2)

`endif

// ==== src/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    // Address split for storage indexing
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_LANES_W-1:0]  lane;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [1:0]                 inword;
    } cache_addr_s;

    // Raw view for the bus, field view for the arrays
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        cache_addr_s              fields;
    } cache_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FLUSH_SCAN,
        FLUSH_WRITE
    } cache_state_e;

endpackage

// ==== src/storage_if.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

interface storage_if;
    import cache_pkg::*;

    // Lookup, result valid one cycle later
    logic                         lookup;
    cache_addr_u                  lookup_addr;
    // Way for writes, line reads and victim report
    logic [`CACHE_WAYS_W-1:0]     way;
    // Byte-masked word write
    logic                         data_we;
    logic [`CACHE_LANES_W-1:0]    wr_lane;
    logic [`CACHE_OFFSET_W-1:0]   wr_offset;
    logic [31:0]                  wr_data;
    logic [3:0]                   wr_mask;
    // Line state updates
    logic                         tag_we;
    logic                         valid_set;
    logic                         dirty_set;
    logic                         line_clear;
    // Read address when no lookup is issued
    logic [`CACHE_LANES_W-1:0]    rd_lane;
    logic [`CACHE_OFFSET_W-1:0]   rd_offset;
    // Results from storage
    logic                         hit;
    logic [`CACHE_WAYS_W-1:0]     hit_way;
    logic [31:0]                  rd_data;
    logic                         victim_dirty;
    logic [`CACHE_TAG_W-1:0]      victim_tag;

    modport control (
        output lookup, lookup_addr, way, data_we, wr_lane, wr_offset, wr_data, wr_mask,
        output tag_we, valid_set, dirty_set, line_clear, rd_lane, rd_offset,
        input  hit, hit_way, rd_data, victim_dirty, victim_tag
    );

    modport storage (
        input  lookup, lookup_addr, way, data_we, wr_lane, wr_offset, wr_data, wr_mask,
        input  tag_we, valid_set, dirty_set, line_clear, rd_lane, rd_offset,
        output hit, hit_way, rd_data, victim_dirty, victim_tag
    );

endinterface

// ==== src/burst_counter.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

module burst_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        step,
    input  logic                        sweep,
    output logic [`CACHE_OFFSET_W-1:0]  count,
    output logic                        last,
    output logic [`CACHE_LANES_W-1:0]   sweep_lane,
    output logic [`CACHE_WAYS_W-1:0]    sweep_way
);
    localparam int PAIR_W = `CACHE_WAYS_W + `CACHE_LANES_W;
    localparam int CNT_W = PAIR_W + `CACHE_OFFSET_W;

    // Way and lane on top, word index at the bottom
    logic [CNT_W-1:0] cnt;
    logic             started;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
            // Sweep start rewinds everything, burst start only the word
            if (sweep) begin
                cnt <= '0;
            end else begin
                cnt[`CACHE_OFFSET_W-1:0] <= '0;
            end
        end else if (step) begin
            if (sweep) begin
                cnt[CNT_W-1:`CACHE_OFFSET_W] <= cnt[CNT_W-1:`CACHE_OFFSET_W] + 1'b1;
            end else begin
                cnt[`CACHE_OFFSET_W-1:0] <= cnt[`CACHE_OFFSET_W-1:0] + 1'b1;
            end
        end
    end

    assign count = cnt[`CACHE_OFFSET_W-1:0];
    assign sweep_lane = cnt[`CACHE_OFFSET_W +: `CACHE_LANES_W];
    assign sweep_way = cnt[CNT_W-1 -: `CACHE_WAYS_W];
    // Final pair in sweep mode, final beat otherwise
    assign last = sweep ? &cnt[CNT_W-1:`CACHE_OFFSET_W] : &count;

    a_step_started: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> started);

endmodule

// ==== src/cache_storage.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_storage (
    input  logic        clk,
    input  logic        rst_n,
    storage_if.storage  sif
);
    localparam int IDX_W = `CACHE_LANES_W + `CACHE_OFFSET_W;

    // Arrays per way
    logic [31:0]                data_mem [`CACHE_WAYS][1 << IDX_W];
    logic [`CACHE_TAG_W-1:0]    tag_mem [`CACHE_WAYS][`CACHE_LANES];
    logic [`CACHE_LANES-1:0]    valid [`CACHE_WAYS];
    logic [`CACHE_LANES-1:0]    dirty [`CACHE_WAYS];

    // Registered read of all ways
    logic [31:0]                data_q [`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0]    tag_q [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]     valid_q;
    logic [`CACHE_WAYS-1:0]     dirty_q;
    logic [`CACHE_TAG_W-1:0]    cmp_tag_q;
    logic [`CACHE_WAYS_W-1:0]   way_q;
    logic                       lookup_q;

    logic [`CACHE_WAYS-1:0]     hit_vec;
    logic [`CACHE_WAYS_W-1:0]   sel_way;
    logic [`CACHE_LANES_W-1:0]  rd_lane;
    logic [IDX_W-1:0]           rd_idx;
    logic [IDX_W-1:0]           wr_idx;

    // Lookup address wins over the line read address
    always_comb begin
        if (sif.lookup) begin
            rd_lane = sif.lookup_addr.fields.lane;
            rd_idx = {sif.lookup_addr.fields.lane, sif.lookup_addr.fields.offset};
        end else begin
            rd_lane = sif.rd_lane;
            rd_idx = {sif.rd_lane, sif.rd_offset};
        end
        wr_idx = {sif.wr_lane, sif.wr_offset};
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            data_q[w] <= data_mem[w][rd_idx];
            tag_q[w] <= tag_mem[w][rd_lane];
        end
        cmp_tag_q <= sif.lookup_addr.fields.tag;
        way_q <= sif.way;
        // Only masked bytes change
        if (sif.data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (sif.wr_mask[b]) begin
                    data_mem[sif.way][wr_idx][8*b +: 8] <= sif.wr_data[8*b +: 8];
                end
            end
        end
        if (sif.tag_we) begin
            tag_mem[sif.way][sif.wr_lane] <= sif.lookup_addr.fields.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            valid_q <= '0;
            dirty_q <= '0;
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= sif.lookup;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_q[w] <= valid[w][rd_lane];
                dirty_q[w] <= dirty[w][rd_lane];
            end
            if (sif.line_clear) begin
                valid[sif.way][sif.wr_lane] <= 1'b0;
                dirty[sif.way][sif.wr_lane] <= 1'b0;
            end
            // Freshly refilled line starts clean
            if (sif.valid_set) begin
                valid[sif.way][sif.wr_lane] <= 1'b1;
                dirty[sif.way][sif.wr_lane] <= 1'b0;
            end
            if (sif.dirty_set) begin
                dirty[sif.way][sif.wr_lane] <= 1'b1;
            end
        end
    end

    always_comb begin
        sif.hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tag_q[w] == cmp_tag_q);
            if (hit_vec[w]) begin
                sif.hit_way = w[`CACHE_WAYS_W-1:0];
            end
        end
        // Compare means something only right after a lookup
        sif.hit = lookup_q && |hit_vec;
        sel_way = sif.hit ? sif.hit_way : way_q;
        sif.rd_data = data_q[sel_way];
        sif.victim_dirty = valid_q[way_q] && dirty_q[way_q];
        sif.victim_tag = tag_q[way_q];
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_q |-> $onehot0(hit_vec));

endmodule

// ==== src/cache_control.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_control (
    input  logic                        clk,
    input  logic                        rst_n,
    // Core port
    input  logic [`CACHE_ADDR_W-1:0]    c_address,
    input  logic                        c_load,
    input  logic                        c_store,
    input  logic [31:0]                 c_store_data,
    input  logic [3:0]                  c_byteenable,
    output logic [31:0]                 c_load_data,
    output logic                        c_wait,
    output logic                        c_done,
    input  logic                        c_flush,
    output logic                        c_flushing,
    output logic                        c_flush_done,
    // Burst memory port
    output logic [`CACHE_ADDR_W-1:0]    m_address,
    output logic [`CACHE_OFFSET_W:0]    m_burstcount,
    output logic                        m_read,
    output logic                        m_write,
    output logic [31:0]                 m_writedata,
    input  logic                        m_waitrequest,
    input  logic [31:0]                 m_readdata,
    input  logic                        m_readdatavalid,
    // Storage arrays
    storage_if.control                  sif,
    // Burst and sweep counter
    output logic                        start,
    output logic                        step,
    output logic                        sweep,
    input  logic [`CACHE_OFFSET_W-1:0]  count,
    input  logic                        last,
    input  logic [`CACHE_LANES_W-1:0]   sweep_lane,
    input  logic [`CACHE_WAYS_W-1:0]    sweep_way
);
    import cache_pkg::*;

    cache_state_e               state;
    // Latched core request
    cache_addr_u                req_addr;
    logic                       req_store;
    logic [31:0]                req_data;
    logic [3:0]                 req_mask;
    // Line being written back, and refill start
    cache_addr_u                wb_addr;
    cache_addr_u                line_addr;
    // Round-robin victim
    logic [`CACHE_WAYS_W-1:0]   rr_way;
    // Refill command already taken by memory
    logic                       read_acc;
    // Second flush scan cycle where line state is readable
    logic                       scan_rd;
    logic                       accept;
    logic                       flush_ph;
    logic                       wr_beat;
    logic [`CACHE_LANES_W-1:0]  line_lane;

    always_comb begin
        // Requests ignored while a done pulse is out
        accept = !c_done && !c_flush_done;
        flush_ph = (state == FLUSH_SCAN) || (state == FLUSH_WRITE);
        wr_beat = m_write && !m_waitrequest;
        line_lane = flush_ph ? sweep_lane : req_addr.fields.lane;
        line_addr = req_addr;
        line_addr.fields.offset = '0;
        line_addr.fields.inword = '0;

        // Flush wins over a load or store
        sif.lookup = (state == IDLE) && accept && !c_flush && (c_load || c_store);
        sif.lookup_addr.raw = (state == IDLE) ? c_address : req_addr.raw;
        if (flush_ph) begin
            sif.way = sweep_way;
        end else if ((state == LOOKUP) && sif.hit) begin
            sif.way = sif.hit_way;
        end else begin
            sif.way = rr_way;
        end
        sif.rd_lane = line_lane;
        sif.wr_lane = line_lane;
        // Read one word ahead so write data is ready when a beat is taken
        if ((state == WRITEBACK) || (state == FLUSH_WRITE)) begin
            sif.rd_offset = count + (`CACHE_OFFSET_W)'(wr_beat);
        end else begin
            sif.rd_offset = '0;
        end
        sif.wr_offset = (state == REFILL) ? count : req_addr.fields.offset;
        sif.wr_data = (state == REFILL) ? m_readdata : req_data;
        sif.wr_mask = (state == REFILL) ? 4'hf : req_mask;
        sif.dirty_set = (state == LOOKUP) && sif.hit && req_store;
        sif.data_we = sif.dirty_set || ((state == REFILL) && m_readdatavalid);
        // Last refill word makes the line valid and clean
        sif.tag_we = (state == REFILL) && m_readdatavalid && last;
        sif.valid_set = sif.tag_we;
        sif.line_clear = ((state == FLUSH_SCAN) && scan_rd && !sif.victim_dirty) ||
                         ((state == FLUSH_WRITE) && wr_beat && last);

        // Counter walks pairs in scan and words elsewhere
        sweep = (state == IDLE) || (state == FLUSH_SCAN);
        start = ((state == IDLE) && accept && c_flush) || ((state == LOOKUP) && !sif.hit);
        step = wr_beat || ((state == REFILL) && m_readdatavalid) ||
               ((state == FLUSH_SCAN) && scan_rd && !sif.victim_dirty && !last);

        m_read = (state == REFILL) && !read_acc;
        m_write = (state == WRITEBACK) || (state == FLUSH_WRITE);
        m_address = (state == REFILL) ? line_addr.raw : wb_addr.raw;
        m_burstcount = (`CACHE_OFFSET_W + 1)'(`CACHE_WORDS);
        m_writedata = sif.rd_data;

        c_wait = (c_load || c_store) && !c_done;
        c_flushing = c_flush && !c_flush_done;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            rr_way <= '0;
            read_acc <= 1'b0;
            scan_rd <= 1'b0;
            c_done <= 1'b0;
            c_flush_done <= 1'b0;
        end else begin
            c_done <= 1'b0;
            c_flush_done <= 1'b0;
            read_acc <= (state == REFILL) && (read_acc || (m_read && !m_waitrequest));
            case (state)
                IDLE: begin
                    if (accept && c_flush) begin
                        scan_rd <= 1'b0;
                        state <= FLUSH_SCAN;
                    end else if (sif.lookup) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (sif.hit) begin
                        c_done <= 1'b1;
                        state <= IDLE;
                    end else if (sif.victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    if (wr_beat && last) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    // Held request looks up again in IDLE and hits
                    if (m_readdatavalid && last) begin
                        rr_way <= rr_way + 1'b1;
                        state <= IDLE;
                    end
                end
                FLUSH_SCAN: begin
                    scan_rd <= !scan_rd;
                    if (scan_rd && sif.victim_dirty) begin
                        state <= FLUSH_WRITE;
                    end else if (scan_rd && last) begin
                        c_flush_done <= 1'b1;
                        state <= IDLE;
                    end
                end
                FLUSH_WRITE: begin
                    // Rescan the now clean pair before moving on
                    if (wr_beat && last) begin
                        state <= FLUSH_SCAN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sif.lookup) begin
            req_addr.raw <= c_address;
            req_store <= c_store;
            req_data <= c_store_data;
            req_mask <= c_byteenable;
        end
        if ((state == LOOKUP) && sif.hit && !req_store) begin
            c_load_data <= sif.rd_data;
        end
        // Victim tag is valid on a miss and in the second scan cycle
        if ((state == LOOKUP) || ((state == FLUSH_SCAN) && scan_rd)) begin
            wb_addr.fields.tag <= sif.victim_tag;
            wb_addr.fields.lane <= line_lane;
            wb_addr.fields.offset <= '0;
            wb_addr.fields.inword <= '0;
        end
    end

    // Memory stall holds the read command and its address
    a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (m_read && m_waitrequest) |=> (m_read && $stable(m_address)));
    // Memory stall holds the whole write beat
    a_write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (m_write && m_waitrequest) |=>
        (m_write && $stable(m_address) && $stable(m_writedata)));
    // Read words come only for an accepted refill
    a_data_expected: assert property (@(posedge clk) disable iff (!rst_n)
        m_readdatavalid |-> ((state == REFILL) && read_acc));

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Core side
    input  logic [`CACHE_ADDR_W-1:0]    c_address,
    input  logic                        c_load,
    input  logic                        c_store,
    input  logic [31:0]                 c_store_data,
    input  logic [3:0]                  c_byteenable,
    output logic [31:0]                 c_load_data,
    output logic                        c_wait,
    output logic                        c_done,
    input  logic                        c_flush,
    output logic                        c_flushing,
    output logic                        c_flush_done,
    // Memory side
    output logic [`CACHE_ADDR_W-1:0]    m_address,
    output logic [`CACHE_OFFSET_W:0]    m_burstcount,
    output logic                        m_read,
    output logic                        m_write,
    output logic [31:0]                 m_writedata,
    input  logic                        m_waitrequest,
    input  logic [31:0]                 m_readdata,
    input  logic                        m_readdatavalid
);
    // Counter steering
    logic                       start;
    logic                       step;
    logic                       sweep;
    logic [`CACHE_OFFSET_W-1:0] count;
    logic                       last;
    logic [`CACHE_LANES_W-1:0]  sweep_lane;
    logic [`CACHE_WAYS_W-1:0]   sweep_way;

    storage_if sif ();

    cache_control control_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .c_address      (c_address),
        .c_load         (c_load),
        .c_store        (c_store),
        .c_store_data   (c_store_data),
        .c_byteenable   (c_byteenable),
        .c_load_data    (c_load_data),
        .c_wait         (c_wait),
        .c_done         (c_done),
        .c_flush        (c_flush),
        .c_flushing     (c_flushing),
        .c_flush_done   (c_flush_done),
        .m_address      (m_address),
        .m_burstcount   (m_burstcount),
        .m_read         (m_read),
        .m_write        (m_write),
        .m_writedata    (m_writedata),
        .m_waitrequest  (m_waitrequest),
        .m_readdata     (m_readdata),
        .m_readdatavalid(m_readdatavalid),
        .sif            (sif.control),
        .start          (start),
        .step           (step),
        .sweep          (sweep),
        .count          (count),
        .last           (last),
        .sweep_lane     (sweep_lane),
        .sweep_way      (sweep_way)
    );

    burst_counter counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .step       (step),
        .sweep      (sweep),
        .count      (count),
        .last       (last),
        .sweep_lane (sweep_lane),
        .sweep_way  (sweep_way)
    );

    cache_storage storage_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sif    (sif.storage)
    );

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

module mem_model #(
    parameter int SEED = 32'h544a
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CACHE_ADDR_W-1:0]    m_address,
    input  logic [`CACHE_OFFSET_W:0]    m_burstcount,
    input  logic                        m_read,
    input  logic                        m_write,
    input  logic [31:0]                 m_writedata,
    output logic                        m_waitrequest,
    output logic [31:0]                 m_readdata,
    output logic                        m_readdatavalid,
    // Side port for comparing memory contents
    input  logic [`CACHE_ADDR_W-1:0]    peek_addr,
    output logic [31:0]                 peek_data
);
    // 4 KB window, upper address bits ignored
    logic [31:0]                mem [1024];
    integer                     seed;
    logic [9:0]                 rd_ptr;
    logic [`CACHE_OFFSET_W:0]   rd_left;
    logic [`CACHE_OFFSET_W:0]   wr_idx;
    // Bus values as they stood at the edge
    logic                       rst_s;
    logic                       rd_cmd;
    logic                       wr_beat;
    logic [9:0]                 addr_s;
    logic [`CACHE_OFFSET_W:0]   burst_s;
    logic [31:0]                wdata_s;
    logic [9:0]                 paddr_s;

    initial begin
        seed = SEED;
        // Unwritten word reads as its byte address with a marker
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i << 2) ^ 32'hA5A5_0000;
        end
        m_waitrequest = 1'b0;
        m_readdata = '0;
        m_readdatavalid = 1'b0;
        peek_data = '0;
        rd_ptr = '0;
        rd_left = '0;
        wr_idx = '0;
    end

    always @(posedge clk) begin
        rst_s = rst_n;
        rd_cmd = m_read && !m_waitrequest;
        wr_beat = m_write && !m_waitrequest;
        addr_s = m_address[11:2];
        burst_s = m_burstcount;
        wdata_s = m_writedata;
        paddr_s = peek_addr[11:2];
        #1;
        // Back-pressure roughly one cycle in four
        m_waitrequest = ($random(seed) & 3) == 0;
        if (!rst_s) begin
            rd_left = '0;
            wr_idx = '0;
            m_readdatavalid = 1'b0;
        end else begin
            // Write beats all carry the burst start address
            if (wr_beat) begin
                mem[addr_s + 10'(wr_idx)] = wdata_s;
                wr_idx = (wr_idx == burst_s - 1'b1) ? '0 : wr_idx + 1'b1;
            end
            if (rd_cmd) begin
                rd_ptr = addr_s;
                rd_left = burst_s;
            end
            // Read words stream back to back after the command
            m_readdatavalid = (rd_left != 0);
            if (rd_left != 0) begin
                m_readdata = mem[rd_ptr];
                rd_ptr = rd_ptr + 1'b1;
                rd_left = rd_left - 1'b1;
            end
        end
        peek_data = mem[paddr_s];
    end

endmodule

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_tb;
    localparam int SEED = 32'h544a;
    // About four times the longest run
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int CHECK_WORDS = 256;
    // Expected outcome of a lookup
    localparam int ANY = 0;
    localparam int HIT = 1;
    localparam int MISS = 2;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [`CACHE_ADDR_W-1:0]   c_address;
    logic                       c_load;
    logic                       c_store;
    logic [31:0]                c_store_data;
    logic [3:0]                 c_byteenable;
    logic [31:0]                c_load_data;
    logic                       c_wait;
    logic                       c_done;
    logic                       c_flush;
    logic                       c_flushing;
    logic                       c_flush_done;
    logic [`CACHE_ADDR_W-1:0]   m_address;
    logic [`CACHE_OFFSET_W:0]   m_burstcount;
    logic                       m_read;
    logic                       m_write;
    logic [31:0]                m_writedata;
    logic                       m_waitrequest;
    logic [31:0]                m_readdata;
    logic                       m_readdatavalid;
    logic [31:0]                peek_addr;
    logic [31:0]                peek_data;

    // Reference memory and what the checks expect
    logic [31:0]                ref_mem [1024];
    logic [31:0]                exp_data;
    logic                       chk_load;
    logic                       chk_hit;
    logic                       chk_miss;
    logic [31:0]                peek_exp;
    logic                       peek_en;
    // Aligned with the registered peek_data
    logic [31:0]                peek_exp_q;
    logic [31:0]                peek_addr_q;
    logic                       peek_en_q;
    int                         req_cycles = 0;
    int                         cycles = 0;
    int                         errors = 0;
    int                         loads = 0;
    int                         words = 0;
    integer                     seed = SEED;

    cache_top cache_top_i (.*);

    mem_model #(.SEED(SEED)) mem_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        peek_en_q <= peek_en;
        peek_exp_q <= peek_exp;
        peek_addr_q <= peek_addr;
        // Cycles a request has been held without c_done
        if (!(c_load || c_store)) begin
            req_cycles <= 0;
        end else if (!c_done) begin
            req_cycles <= req_cycles + 1;
        end
    end

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        (c_done && chk_load) |-> (c_load_data == exp_data))
        else begin
            errors++;
            $display("FAILED at %0t: c_load_data expected %h, got %h",
                     $time, $sampled(exp_data), $sampled(c_load_data));
        end
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (c_done && chk_hit) |-> (req_cycles == 2))
        else begin
            errors++;
            $display("FAILED at %0t: c_done latency expected 2, got %0d",
                     $time, $sampled(req_cycles));
        end
    a_miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (c_done && chk_miss) |-> (req_cycles > 2))
        else begin
            errors++;
            $display("At %0t a load that should miss finished like a hit", $time);
        end
    a_wait_high: assert property (@(posedge clk) disable iff (!rst_n)
        ((c_load || c_store) && !c_done) |-> c_wait)
        else begin
            errors++;
            $display("At %0t c_wait was low while a request was pending", $time);
        end
    a_flushing_high: assert property (@(posedge clk) disable iff (!rst_n)
        (c_flush && !c_flush_done) |-> c_flushing)
        else begin
            errors++;
            $display("At %0t c_flushing was low during a flush", $time);
        end
    a_mem_word: assert property (@(posedge clk) disable iff (!rst_n)
        peek_en_q |-> (peek_data == peek_exp_q))
        else begin
            errors++;
            $display("FAILED at %0t: peek_data at %h expected %h, got %h", $time,
                     $sampled(peek_addr_q), $sampled(peek_exp_q), $sampled(peek_data));
        end

    // One load or store, held until c_done
    task automatic access(input logic is_store, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] mask, input int mode);
        int w;
        w = int'(addr[11:2]);
        @(posedge clk);
        #1;
        // Only the enabled bytes change
        if (is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    ref_mem[w][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            loads++;
        end
        exp_data = ref_mem[w];
        chk_load = !is_store;
        chk_hit = (mode == HIT);
        chk_miss = (mode == MISS);
        c_address = addr;
        c_store_data = data;
        c_byteenable = is_store ? mask : 4'hf;
        c_store = is_store;
        c_load = !is_store;
        do begin
            @(posedge clk);
            #1;
        end while (!c_done);
        c_load = 1'b0;
        c_store = 1'b0;
    endtask

    task automatic flush_all();
        @(posedge clk);
        #1;
        c_flush = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!c_flush_done);
        c_flush = 1'b0;
    endtask

    // Walk the low words of memory, one per cycle
    task automatic check_memory();
        for (int w = 0; w < CHECK_WORDS; w++) begin
            @(posedge clk);
            #1;
            peek_addr = 32'(w) << 2;
            peek_exp = ref_mem[w];
            peek_en = 1'b1;
            words++;
        end
        @(posedge clk);
        #1;
        peek_en = 1'b0;
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a handshake never completed", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] r_addr;
        logic [31:0] r_data;
        logic [3:0]  r_mask;
        logic        r_store;
        rst_n = 1'b0;
        c_address = '0;
        c_load = 1'b0;
        c_store = 1'b0;
        c_store_data = '0;
        c_byteenable = '0;
        c_flush = 1'b0;
        exp_data = '0;
        chk_load = 1'b0;
        chk_hit = 1'b0;
        chk_miss = 1'b0;
        peek_addr = '0;
        peek_exp = '0;
        peek_en = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = (i << 2) ^ 32'hA5A5_0000;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Refill of an untouched line
        access(1'b0, 32'h0A0, '0, 4'hf, MISS);
        // Partial store, then a hit on the merged word
        access(1'b1, 32'h048, 32'h1122_3344, 4'b0101, ANY);
        access(1'b0, 32'h048, '0, 4'hf, HIT);
        // Lane 0 gets three more tags, dirty lines get evicted
        access(1'b1, 32'h104, 32'hDEAD_0104, 4'hf, ANY);
        access(1'b1, 32'h204, 32'hBEEF_0204, 4'b1100, ANY);
        access(1'b1, 32'h304, 32'hCAFE_0304, 4'b0011, ANY);
        access(1'b0, 32'h104, '0, 4'hf, ANY);
        access(1'b0, 32'h204, '0, 4'hf, ANY);
        access(1'b0, 32'h304, '0, 4'hf, ANY);
        access(1'b0, 32'h048, '0, 4'hf, ANY);

        // Flush, compare memory, then a flushed word must miss
        flush_all();
        check_memory();
        access(1'b0, 32'h204, '0, 4'hf, MISS);

        // Random mix over 64 words
        for (int n = 0; n < 300; n++) begin
            r_addr = ($random(seed) & 32'h3f) << 2;
            r_store = ($random(seed) & 1) != 0;
            r_data = $random(seed);
            r_mask = 4'($random(seed));
            access(r_store, r_addr, r_data, r_mask, ANY);
        end
        flush_all();
        check_memory();
        repeat (3) @(posedge clk);

        $display("Loads checked %0d, memory words checked %0d, errors %0d",
                 loads, words, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/cache_pkg.sv
src/storage_if.sv
src/burst_counter.sv
src/cache_storage.sv
src/cache_control.sv
src/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -f sources.f

./obj_dir/Vcache_tb > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
exit 0
